// File: hw/axi_axil_adapter_wr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_axil_adapter_wr (
  input  wire logic                     clk,
  input  wire logic                     rst_n,

  // axi slave write port.
  input  wire axil_bridge_pkg::axi_aw_t aw,
  input  wire logic                     aw_valid,
  output logic                          aw_ready,
  input  wire axil_bridge_pkg::axi_w_t  w,
  input  wire logic                     w_valid,
  output logic                          w_ready,
  output axil_bridge_pkg::axi_b_t       b,
  output logic                          b_valid,
  input  wire logic                     b_ready,

  // axi-lite master write port.
  output axil_bridge_pkg::addr_t        axil_aw_addr,
  output logic                          axil_aw_valid,
  input  wire logic                     axil_aw_ready,
  output axil_bridge_pkg::axil_w_t      axil_w,
  output logic                          axil_w_valid,
  input  wire logic                     axil_w_ready,
  input  wire axil_bridge_pkg::resp_e   axil_b_resp,
  input  wire logic                     axil_b_valid,
  output logic                          axil_b_ready
);

  typedef enum logic [1:0] {
    idle,
    beat,
    resp_wait,
    burst_resp
  } state_e;

  state_e state;

  axil_bridge_pkg::axi_aw_t cmd;      // command held for the whole burst.
  axil_bridge_pkg::addr_t   cur_addr;
  axil_bridge_pkg::addr_t   next_addr;

  logic aw_done;                       // axi-lite aw already went through.
  logic w_done;
  logic last_beat;
  logic err;                           // sticky across the burst.

  logic aw_fire;
  logic w_fire;
  logic aw_complete;
  logic w_complete;
  logic beat_fire;

  axi_burst_addr burst_addr_i (
    .addr      (cur_addr),
    .size      (cmd.size),
    .len       (cmd.len),
    .burst     (cmd.burst),
    .next_addr (next_addr)
  );

  // address and data pass straight through while a beat is presented.
  assign axil_aw_addr = cur_addr;
  assign axil_w = '{data: w.data, strb: w.strb};

  assign axil_aw_valid = (state == beat) && w_valid && !aw_done;
  assign axil_w_valid = (state == beat) && w_valid && !w_done;

  assign aw_fire = axil_aw_valid && axil_aw_ready;
  assign w_fire = axil_w_valid && axil_w_ready;

  assign aw_complete = aw_done || aw_fire;
  assign w_complete = w_done || w_fire;

  // the axi beat is taken only once both lite channels are through.
  assign beat_fire = (state == beat) && w_valid && aw_complete && w_complete;
  assign w_ready = beat_fire;

  assign axil_b_ready = (state == resp_wait);

  assign aw_ready = (state == idle);

  assign b_valid = (state == burst_resp);
  assign b.id = cmd.id;
  assign b.resp = err ? axil_bridge_pkg::resp_slverr : axil_bridge_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= idle;
      aw_done   <= 1'b0;
      w_done    <= 1'b0;
      last_beat <= 1'b0;
      err       <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (aw_valid) begin
            err   <= 1'b0;
            state <= beat;
          end
        end
        beat: begin
          if (beat_fire) begin
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            last_beat <= w.last;
            state     <= resp_wait;
          end else begin
            aw_done <= aw_complete;      // remember a lone completion.
            w_done  <= w_complete;
          end
        end
        resp_wait: begin
          if (axil_b_valid) begin
            if (axil_b_resp == axil_bridge_pkg::resp_slverr) begin
              err <= 1'b1;
            end
            if (last_beat) begin
              state <= burst_resp;
            end else begin
              state <= beat;
            end
          end
        end
        burst_resp: begin
          if (b_ready) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // command and beat address.
  always_ff @(posedge clk) begin
    if (state == idle && aw_valid) begin
      cmd      <= aw;
      cur_addr <= aw.addr;
    end else if (state == resp_wait && axil_b_valid && !last_beat) begin
      cur_addr <= next_addr;
    end
  end

endmodule

`default_nettype wire

// File: hw/axi_burst_addr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_addr (
  input  wire axil_bridge_pkg::addr_t  addr,
  input  wire logic [2:0]              size,
  input  wire logic [7:0]              len,
  input  wire axil_bridge_pkg::burst_e burst,
  output axil_bridge_pkg::addr_t       next_addr
);

  axil_bridge_pkg::addr_t step;
  axil_bridge_pkg::addr_t incr_addr;
  axil_bridge_pkg::addr_t wrap_bytes;
  axil_bridge_pkg::addr_t wrap_mask;
  axil_bridge_pkg::addr_t wrap_base;
  axil_bridge_pkg::addr_t wrap_addr;

  // bytes moved per beat.
  assign step = axil_bridge_pkg::addr_t'(1) << size;

  assign incr_addr = addr + step;

  // the wrap window is (len+1) beats wide and aligned to its own size.
  assign wrap_bytes = (axil_bridge_pkg::addr_t'(len) + axil_bridge_pkg::addr_t'(1)) << size;
  assign wrap_mask = wrap_bytes - axil_bridge_pkg::addr_t'(1);
  assign wrap_base = addr & ~wrap_mask;

  // offset rolls over to the base at the top of the window.
  assign wrap_addr = wrap_base | (incr_addr & wrap_mask);

  always_comb begin
    unique case (burst)
      axil_bridge_pkg::burst_fixed: begin
        next_addr = addr;
      end
      axil_bridge_pkg::burst_incr: begin
        next_addr = incr_addr;
      end
      axil_bridge_pkg::burst_wrap: begin
        next_addr = wrap_addr;
      end
      default: begin
        next_addr = addr;            // reserved encoding holds the address.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/axi_wr_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_bridge_top (
  input  wire logic                                        clk,
  input  wire logic                                        rst_n,

  input  wire axil_bridge_pkg::axi_aw_t                    aw,
  input  wire logic                                        aw_valid,
  output logic                                             aw_ready,
  input  wire axil_bridge_pkg::axi_w_t                     w,
  input  wire logic                                        w_valid,
  output logic                                             w_ready,
  output axil_bridge_pkg::axi_b_t                          b,
  output logic                                             b_valid,
  input  wire logic                                        b_ready,

  input  wire logic [axil_bridge_pkg::reg_index_width-1:0] cfg_index,
  output axil_bridge_pkg::data_t                           cfg_data
);

  // internal axi-lite write bus.
  axil_bridge_pkg::addr_t   axil_aw_addr;
  logic                     axil_aw_valid;
  logic                     axil_aw_ready;
  axil_bridge_pkg::axil_w_t axil_w;
  logic                     axil_w_valid;
  logic                     axil_w_ready;
  axil_bridge_pkg::resp_e   axil_b_resp;
  logic                     axil_b_valid;
  logic                     axil_b_ready;

  axi_axil_adapter_wr adapter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b             (b),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .axil_aw_addr  (axil_aw_addr),
    .axil_aw_valid (axil_aw_valid),
    .axil_aw_ready (axil_aw_ready),
    .axil_w        (axil_w),
    .axil_w_valid  (axil_w_valid),
    .axil_w_ready  (axil_w_ready),
    .axil_b_resp   (axil_b_resp),
    .axil_b_valid  (axil_b_valid),
    .axil_b_ready  (axil_b_ready)
  );

  axil_reg_bank reg_bank_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .axil_aw_addr  (axil_aw_addr),
    .axil_aw_valid (axil_aw_valid),
    .axil_aw_ready (axil_aw_ready),
    .axil_w        (axil_w),
    .axil_w_valid  (axil_w_valid),
    .axil_w_ready  (axil_w_ready),
    .axil_b_resp   (axil_b_resp),
    .axil_b_valid  (axil_b_valid),
    .axil_b_ready  (axil_b_ready),
    .cfg_index     (cfg_index),
    .cfg_data      (cfg_data)
  );

endmodule

`default_nettype wire

// File: hw/axil_bridge_pkg.sv
`default_nettype none

package axil_bridge_pkg;

  localparam int addr_width = 16;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int id_width = 4;
  localparam int reg_count = 16;
  localparam int reg_index_width = $clog2(reg_count);

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [id_width-1:0] id_t;

  // axi burst type encoding.
  typedef enum logic [1:0] {
    burst_fixed = 2'd0,
    burst_incr  = 2'd1,
    burst_wrap  = 2'd2
  } burst_e;

  // only okay and slverr are produced here.
  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } resp_e;

  // write address command.
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;       // beats minus one.
    logic [2:0] size;      // log2 of bytes per beat.
    burst_e     burst;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } axi_b_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

endpackage

`default_nettype wire

// File: hw/axil_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module axil_reg_bank (
  input  wire logic                                        clk,
  input  wire logic                                        rst_n,

  input  wire axil_bridge_pkg::addr_t                      axil_aw_addr,
  input  wire logic                                        axil_aw_valid,
  output logic                                             axil_aw_ready,
  input  wire axil_bridge_pkg::axil_w_t                    axil_w,
  input  wire logic                                        axil_w_valid,
  output logic                                             axil_w_ready,
  output axil_bridge_pkg::resp_e                           axil_b_resp,
  output logic                                             axil_b_valid,
  input  wire logic                                        axil_b_ready,

  // configuration lookup for the consuming hardware.
  input  wire logic [axil_bridge_pkg::reg_index_width-1:0] cfg_index,
  output axil_bridge_pkg::data_t                           cfg_data
);

  axil_bridge_pkg::data_t regs [axil_bridge_pkg::reg_count];

  logic                                        accept;
  logic                                        in_range;
  logic [axil_bridge_pkg::reg_index_width-1:0] word_idx;

  // address and data are taken together, one write at a time.
  assign accept = axil_aw_valid && axil_w_valid && !axil_b_valid;
  assign axil_aw_ready = accept;
  assign axil_w_ready = accept;

  assign word_idx = axil_aw_addr[axil_bridge_pkg::reg_index_width+1:2];

  // anything above the last word is outside the bank.
  assign in_range =
    (axil_aw_addr >> (axil_bridge_pkg::reg_index_width + 2)) == axil_bridge_pkg::addr_t'(0);

  assign cfg_data = regs[cfg_index];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < axil_bridge_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && in_range) begin
      for (int i = 0; i < axil_bridge_pkg::strb_width; i++) begin
        if (axil_w.strb[i]) begin
          regs[word_idx][8*i +: 8] <= axil_w.data[8*i +: 8];   // byte lane i.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      axil_b_valid <= 1'b0;
    end else if (accept) begin
      axil_b_valid <= 1'b1;
    end else if (axil_b_ready) begin
      axil_b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      axil_b_resp <= in_range ? axil_bridge_pkg::resp_okay : axil_bridge_pkg::resp_slverr;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sim.f \
  --top-module axi_wr_bridge_tb \
  --Mdir obj_dir \
  -o axi_wr_bridge_sim

# the log decides the result, so a non-zero exit here does not stop the script
./obj_dir/axi_wr_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: sim.f
hw/axil_bridge_pkg.sv
hw/axi_burst_addr.sv
hw/axi_axil_adapter_wr.sv
hw/axil_reg_bank.sv
hw/axi_wr_bridge_top.sv
verification/axi_wr_bridge_tb.sv

// File: verification/axi_wr_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_bridge_tb;

  localparam int half_period = 50;
  localparam int planned_beats = 4 + 4 + 3 + 6 + 4 + 2;
  localparam int watchdog_cycles = 200 * planned_beats;

  logic                                        clk;
  logic                                        rst_n;
  axil_bridge_pkg::axi_aw_t                    aw;
  logic                                        aw_valid;
  logic                                        aw_ready;
  axil_bridge_pkg::axi_w_t                     w;
  logic                                        w_valid;
  logic                                        w_ready;
  axil_bridge_pkg::axi_b_t                     b;
  logic                                        b_valid;
  logic                                        b_ready;
  logic [axil_bridge_pkg::reg_index_width-1:0] cfg_index;
  axil_bridge_pkg::data_t                      cfg_data;

  axil_bridge_pkg::data_t model [axil_bridge_pkg::reg_count];   // expected register contents.
  logic [31:0]            lcg_state;
  logic                   burst_open;                            // between command and response.
  int                     bursts_done;
  int                     b_count = 0;
  logic                   b_valid_q;

  axi_wr_bridge_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .cfg_index (cfg_index),
    .cfg_data  (cfg_data)
  );

  initial clk = 1'b0;
  always #half_period clk = ~clk;

  // one count per response presented.
  always @(posedge clk) begin
    if (!rst_n) begin
      b_valid_q <= 1'b0;
    end else begin
      b_valid_q <= b_valid;
      if (b_valid && !b_valid_q) begin
        b_count <= b_count + 1;
      end
    end
  end

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %s expected %h got %h", name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  // beats move only inside a burst.
  assert property (@(posedge clk) disable iff (!rst_n) w_ready |-> burst_open)
    else report_failure("w_ready high outside a burst");

  assert property (@(posedge clk) disable iff (!rst_n)
                   (b_valid && !b_ready) |=> (b_valid && $stable(b)))
    else report_failure("b changed or dropped before b_ready");

  assert property (@(posedge clk) disable iff (!rst_n) b_valid |-> !aw_ready)
    else report_failure("aw_ready high while a response is pending");

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // returns 0 when the address falls outside the bank.
  function automatic logic model_write(input axil_bridge_pkg::addr_t addr,
                                       input axil_bridge_pkg::data_t data,
                                       input axil_bridge_pkg::strb_t strb);
    logic [3:0] idx;
    if (32'(addr) >= axil_bridge_pkg::reg_count * 4) begin
      return 1'b0;
    end
    idx = addr[5:2];
    for (int i = 0; i < axil_bridge_pkg::strb_width; i++) begin
      if (strb[i]) begin
        model[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
    return 1'b1;
  endfunction

  function automatic axil_bridge_pkg::addr_t beat_addr_after(
    input axil_bridge_pkg::addr_t  addr,
    input logic [2:0]              size,
    input logic [7:0]              len,
    input axil_bridge_pkg::burst_e burst
  );
    logic [31:0] step;
    logic [31:0] window;
    logic [31:0] base;
    logic [31:0] nxt;
    step = 32'd1 << size;
    nxt = 32'(addr) + step;
    window = (32'(len) + 32'd1) * step;
    base = (32'(addr) / window) * window;
    case (burst)
      axil_bridge_pkg::burst_incr: begin
        return axil_bridge_pkg::addr_t'(nxt);
      end
      axil_bridge_pkg::burst_wrap: begin
        if (nxt >= base + window) begin
          return axil_bridge_pkg::addr_t'(base);      // back to the window start.
        end else begin
          return axil_bridge_pkg::addr_t'(nxt);
        end
      end
      default: begin
        return addr;
      end
    endcase
  endfunction

  task automatic check_regs();
    for (int i = 0; i < axil_bridge_pkg::reg_count; i++) begin
      @(negedge clk);
      cfg_index = 4'(i);
      #1;
      assert (cfg_data == model[4'(i)])
        else report_mismatch($sformatf("cfg_data[%0d]", i), model[4'(i)], cfg_data);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_cmd(input axil_bridge_pkg::id_t id, input axil_bridge_pkg::addr_t addr,
                          input logic [7:0] len, input logic [2:0] size,
                          input axil_bridge_pkg::burst_e burst);
    aw.id = id;
    aw.addr = addr;
    aw.len = len;
    aw.size = size;
    aw.burst = burst;
    aw_valid = 1'b1;
    #1;
    while (!aw_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  task automatic send_beat(input axil_bridge_pkg::data_t data, input axil_bridge_pkg::strb_t strb,
                           input logic last);
    w.data = data;
    w.strb = strb;
    w.last = last;
    w_valid = 1'b1;
    #1;
    while (!w_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
  endtask

  task automatic wait_resp(input axil_bridge_pkg::id_t exp_id,
                           input axil_bridge_pkg::resp_e exp_resp, input int stall);
    axil_bridge_pkg::axi_b_t b_seen;
    #1;
    while (!b_valid) begin
      @(negedge clk);
      #1;
    end
    b_seen = b;
    assert (b_seen.id == exp_id) else report_mismatch("b.id", 32'(exp_id), 32'(b_seen.id));
    assert (b_seen.resp == exp_resp)
      else report_mismatch("b.resp", 32'(exp_resp), 32'(b_seen.resp));
    repeat (stall) begin
      @(negedge clk);
      #1;
      assert (b_valid) else report_failure("b_valid dropped while b_ready was low");
      assert (b == b_seen) else report_mismatch("b", 32'(b_seen), 32'(b));
      assert (!aw_ready) else report_failure("aw_ready high during a stalled response");
    end
    @(negedge clk);
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
    burst_open = 1'b0;
    bursts_done++;
    #1;
    assert (!b_valid) else report_failure("b_valid still high after its transfer");
    assert (b_count == bursts_done)
      else report_mismatch("b_count", 32'(bursts_done), 32'(b_count));
  endtask

  task automatic run_burst(input axil_bridge_pkg::id_t id, input axil_bridge_pkg::addr_t addr,
                           input logic [7:0] len, input logic [2:0] size,
                           input axil_bridge_pkg::burst_e burst, input logic rand_strb,
                           input logic early, input int min_stall);
    axil_bridge_pkg::data_t data_q [$];
    axil_bridge_pkg::strb_t strb_q [$];
    axil_bridge_pkg::addr_t cur;
    logic                   all_ok;
    logic [31:0]            rnd;
    int                     stall;
    cur = addr;
    all_ok = 1'b1;
    for (int n = 0; n <= int'(len); n++) begin
      data_q.push_back(lcg_next());
      rnd = lcg_next();
      strb_q.push_back(rand_strb ? rnd[19:16] : 4'hf);
      if (!model_write(cur, data_q[n], strb_q[n])) begin
        all_ok = 1'b0;
      end
      cur = beat_addr_after(cur, size, len, burst);
    end
    rnd = lcg_next();
    stall = min_stall + int'(rnd[10:8]);
    @(negedge clk);
    if (early) begin
      w.data = data_q[0];                        // beat waits with no command yet.
      w.strb = strb_q[0];
      w.last = (len == 8'd0);
      w_valid = 1'b1;
      repeat (3) @(negedge clk);
    end
    burst_open = 1'b1;
    send_cmd(id, addr, len, size, burst);
    for (int n = 0; n <= int'(len); n++) begin
      send_beat(data_q[n], strb_q[n], n == int'(len));
    end
    w_valid = 1'b0;
    wait_resp(id, all_ok ? axil_bridge_pkg::resp_okay : axil_bridge_pkg::resp_slverr, stall);
    check_regs();
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    stop_with_failure();
  end

  initial begin
    lcg_state = 32'd36;
    rst_n = 1'b0;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    cfg_index = '0;
    burst_open = 1'b0;
    bursts_done = 0;
    for (int i = 0; i < axil_bridge_pkg::reg_count; i++) begin
      model[4'(i)] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (!b_valid) else report_failure("b_valid high after reset");
    assert (aw_ready) else report_failure("aw_ready low after reset");
    assert (!w_ready) else report_failure("w_ready high after reset");
    check_regs();

    // words 4 to 7.
    run_burst(4'h3, 16'h0010, 8'd3, 3'd2, axil_bridge_pkg::burst_incr, 1'b0, 1'b1, 0);
    // starts at word 10 of the window 8 to 11.
    run_burst(4'h5, 16'h0028, 8'd3, 3'd2, axil_bridge_pkg::burst_wrap, 1'b0, 1'b0, 0);
    run_burst(4'h6, 16'h003c, 8'd2, 3'd2, axil_bridge_pkg::burst_fixed, 1'b0, 1'b0, 0);
    // partial strobes over words already written.
    run_burst(4'h9, 16'h000c, 8'd5, 3'd2, axil_bridge_pkg::burst_incr, 1'b1, 1'b0, 0);
    // last two beats land past word 15.
    run_burst(4'ha, 16'h0038, 8'd3, 3'd2, axil_bridge_pkg::burst_incr, 1'b0, 1'b0, 0);
    run_burst(4'hc, 16'h0020, 8'd1, 3'd2, axil_bridge_pkg::burst_incr, 1'b1, 1'b0, 3);

    assert (b_count == bursts_done)
      else report_mismatch("b_count", 32'(bursts_done), 32'(b_count));

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
